// File: all.f
rtl/cp0_pkg.sv
rtl/tlb_if.sv
rtl/cp0_regs.sv
rtl/tlb_array.sv
rtl/tlb_seq.sv
rtl/cp0_top.sv
test/tb_cp0.sv

// File: rtl/cp0_pkg.sv
package cp0_pkg;

	// register numbers, select 0 only
	typedef enum logic [4:0] {
		reg_index    = 5'd0,
		reg_entrylo0 = 5'd2,
		reg_entrylo1 = 5'd3,
		reg_badvaddr = 5'd8,
		reg_count    = 5'd9,
		reg_entryhi  = 5'd10,
		reg_compare  = 5'd11,
		reg_status   = 5'd12,
		reg_cause    = 5'd13,
		reg_epc      = 5'd14
	} reg_num_t;

	// positions in the exc_type request vector
	typedef enum logic [3:0] {
		bit_mod       = 4'd0,
		bit_inval_ds  = 4'd1,
		bit_refill_ds = 4'd2,
		bit_inval_dr  = 4'd3,
		bit_refill_dr = 4'd4,
		bit_inval_in  = 4'd5,
		bit_refill_in = 4'd6,
		bit_ov        = 4'd7,
		bit_ri        = 4'd8,
		bit_bp        = 4'd9,
		bit_sys       = 4'd10,
		bit_ades      = 4'd11,
		bit_rdae      = 4'd12,
		bit_rine      = 4'd13,
		bit_int       = 4'd14
	} exc_bit_t;

	typedef enum logic [4:0] {
		code_int  = 5'h00,
		code_mod  = 5'h01,
		code_tlbl = 5'h02,
		code_tlbs = 5'h03,
		code_adel = 5'h04,
		code_ades = 5'h05,
		code_sys  = 5'h08,
		code_bp   = 5'h09,
		code_ri   = 5'h0a,
		code_ov   = 5'h0c
	} exc_code_t;

	typedef enum logic [1:0] {
		tlb_op_tlbp  = 2'd0,
		tlb_op_tlbr  = 2'd1,
		tlb_op_tlbwi = 2'd2
	} tlb_op_t;

	// entry is {vpn2, asid, g, page0, page1}, page = {pfn, c, d, v}
	localparam int vpn2_w         = 19;
	localparam int asid_w         = 8;
	localparam int page_w         = 25;
	localparam int entry_g_pos    = 2 * page_w;
	localparam int entry_asid_lsb = entry_g_pos + 1;
	localparam int entry_vpn2_lsb = entry_asid_lsb + asid_w;
	localparam int tlb_entry_w    = entry_vpn2_lsb + vpn2_w;

endpackage

// File: rtl/cp0_regs.sv
`timescale 1ns/1ps

module cp0_regs #(
	parameter int tlb_num = 16
) (
	input  logic        clk,
	input  logic        rst,
	input  logic        cp0_wen,
	input  logic [7:0]  cp0_addr,
	input  logic [31:0] cp0_wdata,
	output logic [31:0] cp0_rdata,
	input  logic [14:0] exc_type,
	input  logic [31:0] pc,
	input  logic        is_slot,
	input  logic [5:0]  int_num,
	input  logic [31:0] bad_vaddr,
	input  logic        eret,
	output logic [31:0] epc,
	output logic        int_happen,
	tlb_if.regs_mp      tlb
);
	import cp0_pkg::*;

	localparam int idx_w = $clog2(tlb_num);

	reg_num_t         reg_sel;
	logic             wr_any;
	logic             any_exc;
	logic             tlb_exc;
	logic             addr_exc;
	exc_code_t        exc_code;
	logic [7:0]       status_im;
	logic             status_exl;
	logic             status_ie;
	logic             cause_bd;
	logic             cause_ti;
	logic [5:0]       cause_ip_hw;
	logic [1:0]       cause_ip_sw;
	logic [7:0]       cause_ip;
	exc_code_t        cause_exccode;
	logic [31:0]      cp0_epc;
	logic [31:0]      cp0_badvaddr;
	logic [32:0]      cp0_count;
	logic [31:0]      cp0_compare;
	logic             ti_set;
	logic             index_p;
	logic [idx_w-1:0] index_val;
	logic [vpn2_w-1:0] entryhi_vpn2;
	logic [asid_w-1:0] entryhi_asid;
	logic [page_w:0]  entrylo0;
	logic [page_w:0]  entrylo1;

	assign reg_sel = reg_num_t'(cp0_addr[7:3]);
	assign wr_any  = cp0_wen && cp0_addr[2:0] == 3'd0;

	assign any_exc  = |exc_type;
	assign tlb_exc  = exc_type[bit_refill_in] || exc_type[bit_inval_in]
		|| exc_type[bit_refill_dr] || exc_type[bit_inval_dr]
		|| exc_type[bit_refill_ds] || exc_type[bit_inval_ds] || exc_type[bit_mod];
	assign addr_exc = exc_type[bit_rine] || exc_type[bit_rdae] || exc_type[bit_ades];

	// interrupt, then fetch, decode, data side
	always_comb begin
		if (exc_type[bit_int])
			exc_code = code_int;
		else if (exc_type[bit_rine])
			exc_code = code_adel;
		else if (exc_type[bit_refill_in] || exc_type[bit_inval_in])
			exc_code = code_tlbl;
		else if (exc_type[bit_ri])
			exc_code = code_ri;
		else if (exc_type[bit_sys])
			exc_code = code_sys;
		else if (exc_type[bit_bp])
			exc_code = code_bp;
		else if (exc_type[bit_ov])
			exc_code = code_ov;
		else if (exc_type[bit_rdae])
			exc_code = code_adel;
		else if (exc_type[bit_ades])
			exc_code = code_ades;
		else if (exc_type[bit_refill_dr] || exc_type[bit_inval_dr])
			exc_code = code_tlbl;
		else if (exc_type[bit_refill_ds] || exc_type[bit_inval_ds])
			exc_code = code_tlbs;
		else
			exc_code = code_mod;
	end

	// timer shares IP7
	assign cause_ip   = {cause_ip_hw[5] | cause_ti, cause_ip_hw[4:0], cause_ip_sw};
	assign int_happen = status_ie && !status_exl && |(status_im & cause_ip);

	always_ff @(posedge clk) begin
		if (rst) begin
			status_im  <= 8'h0;
			status_ie  <= 1'b0;
			status_exl <= 1'b0;
		end else begin
			if (wr_any && reg_sel == reg_status) begin
				status_im <= cp0_wdata[15:8];
				status_ie <= cp0_wdata[0];
			end
			if (any_exc)
				status_exl <= 1'b1;
			else if (eret)
				status_exl <= 1'b0;
			else if (wr_any && reg_sel == reg_status)
				status_exl <= cp0_wdata[1];
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			cause_bd      <= 1'b0;
			cause_exccode <= code_int;
			cause_ip_sw   <= 2'b0;
		end else begin
			if (any_exc && !status_exl)
				cause_bd <= is_slot;
			if (any_exc)
				cause_exccode <= exc_code;
			if (wr_any && reg_sel == reg_cause)
				cause_ip_sw <= cp0_wdata[9:8];
		end
	end

	// hardware lines sampled every cycle
	always_ff @(posedge clk) begin
		if (rst)
			cause_ip_hw <= 6'h0;
		else
			cause_ip_hw <= int_num;
	end

	// epc is held while EXL is set
	always_ff @(posedge clk) begin
		if (any_exc && !status_exl)
			cp0_epc <= is_slot ? pc - 32'd4 : pc;
		else if (wr_any && reg_sel == reg_epc)
			cp0_epc <= cp0_wdata;
	end

	assign epc = cp0_epc;

	always_ff @(posedge clk) begin
		if (addr_exc || tlb_exc)
			cp0_badvaddr <= bad_vaddr;
	end

	// count lsb is a half-rate prescaler
	always_ff @(posedge clk) begin
		if (rst)
			cp0_count <= 33'h0;
		else if (wr_any && reg_sel == reg_count)
			cp0_count <= {cp0_wdata, 1'b0};
		else
			cp0_count <= cp0_count + 33'd1;
	end

	always_ff @(posedge clk) begin
		if (rst)
			cp0_compare <= 32'h0;
		else if (wr_any && reg_sel == reg_compare)
			cp0_compare <= cp0_wdata;
	end

	// fires as count steps onto compare
	assign ti_set = cp0_count[0] && (cp0_count[32:1] + 32'd1 == cp0_compare);

	always_ff @(posedge clk) begin
		if (rst)
			cause_ti <= 1'b0;
		else if (wr_any && reg_sel == reg_compare)
			cause_ti <= 1'b0;
		else if (ti_set)
			cause_ti <= 1'b1;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			index_p   <= 1'b0;
			index_val <= '0;
		end else if (tlb.probe_wen) begin
			index_p   <= tlb.probe_result[31];
			index_val <= tlb.probe_result[idx_w-1:0];
		end else if (wr_any && reg_sel == reg_index) begin
			index_val <= cp0_wdata[idx_w-1:0];
		end
	end

	always_ff @(posedge clk) begin
		if (tlb_exc) begin
			entryhi_vpn2 <= bad_vaddr[31:13];
		end else if (tlb.read_wen) begin
			entryhi_vpn2 <= tlb.read_entry[entry_vpn2_lsb +: vpn2_w];
			entryhi_asid <= tlb.read_entry[entry_asid_lsb +: asid_w];
		end else if (wr_any && reg_sel == reg_entryhi) begin
			entryhi_vpn2 <= cp0_wdata[31:13];
			entryhi_asid <= cp0_wdata[asid_w-1:0];
		end
	end

	// g is split back onto both pages on a read
	always_ff @(posedge clk) begin
		if (tlb.read_wen) begin
			entrylo0 <= {tlb.read_entry[page_w +: page_w], tlb.read_entry[entry_g_pos]};
			entrylo1 <= {tlb.read_entry[0 +: page_w], tlb.read_entry[entry_g_pos]};
		end else begin
			if (wr_any && reg_sel == reg_entrylo0)
				entrylo0 <= cp0_wdata[page_w:0];
			if (wr_any && reg_sel == reg_entrylo1)
				entrylo1 <= cp0_wdata[page_w:0];
		end
	end

	assign tlb.probe_entryhi = {entryhi_vpn2, 5'h0, entryhi_asid};
	assign tlb.index         = index_val;
	assign tlb.write_entry   = {entryhi_vpn2, entryhi_asid, entrylo0[0] & entrylo1[0],
		entrylo0[page_w:1], entrylo1[page_w:1]};

	always_comb begin
		cp0_rdata = 32'h0;
		if (cp0_addr[2:0] == 3'd0) begin
			case (reg_sel)
				reg_index:    cp0_rdata = {index_p, {(31 - idx_w){1'b0}}, index_val};
				reg_entrylo0: cp0_rdata = {6'h0, entrylo0};
				reg_entrylo1: cp0_rdata = {6'h0, entrylo1};
				reg_badvaddr: cp0_rdata = cp0_badvaddr;
				reg_count:    cp0_rdata = cp0_count[32:1];
				reg_entryhi:  cp0_rdata = {entryhi_vpn2, 5'h0, entryhi_asid};
				reg_compare:  cp0_rdata = cp0_compare;
				// bev is hardwired to 1
				reg_status:   cp0_rdata = {9'h0, 1'b1, 6'h0, status_im, 6'h0, status_exl, status_ie};
				reg_cause:    cp0_rdata = {cause_bd, cause_ti, 14'h0, cause_ip, 1'b0,
					cause_exccode, 2'b0};
				reg_epc:      cp0_rdata = cp0_epc;
				default:      cp0_rdata = 32'h0;
			endcase
		end
	end

endmodule

// File: rtl/cp0_top.sv
`timescale 1ns/1ps

module cp0_top #(
	parameter int tlb_num = 16
) (
	input  logic        clk,
	input  logic        rst,
	input  logic        cp0_wen,
	input  logic [7:0]  cp0_addr,
	input  logic [31:0] cp0_wdata,
	output logic [31:0] cp0_rdata,
	input  logic [14:0] exc_type,
	input  logic [31:0] pc,
	input  logic        is_slot,
	input  logic [5:0]  int_num,
	input  logic [31:0] bad_vaddr,
	input  logic        eret,
	output logic [31:0] epc,
	output logic        int_happen,
	input  logic        tlb_valid,
	input  logic [1:0]  tlb_op,
	output logic        tlb_ready
);
	import cp0_pkg::*;

	tlb_if #(.tlb_num(tlb_num)) tlb ();

	cp0_regs #(
		.tlb_num(tlb_num)
	) u_regs (
		.clk        (clk),
		.rst        (rst),
		.cp0_wen    (cp0_wen),
		.cp0_addr   (cp0_addr),
		.cp0_wdata  (cp0_wdata),
		.cp0_rdata  (cp0_rdata),
		.exc_type   (exc_type),
		.pc         (pc),
		.is_slot    (is_slot),
		.int_num    (int_num),
		.bad_vaddr  (bad_vaddr),
		.eret       (eret),
		.epc        (epc),
		.int_happen (int_happen),
		.tlb        (tlb)
	);

	tlb_seq #(
		.tlb_num(tlb_num)
	) u_seq (
		.clk       (clk),
		.rst       (rst),
		.tlb_valid (tlb_valid),
		.tlb_op    (tlb_op_t'(tlb_op)),
		.tlb_ready (tlb_ready),
		.tlb       (tlb)
	);

	tlb_array #(
		.tlb_num(tlb_num)
	) u_array (
		.clk (clk),
		.rst (rst),
		.tlb (tlb)
	);

endmodule

// File: rtl/tlb_array.sv
`timescale 1ns/1ps

module tlb_array #(
	parameter int tlb_num = 16
) (
	input  logic     clk,
	input  logic     rst,
	tlb_if.array_mp  tlb
);
	import cp0_pkg::*;

	localparam int idx_w = $clog2(tlb_num);

	logic [tlb_entry_w-1:0] entries [tlb_num];
	logic [tlb_num-1:0]     entry_vld;
	logic [tlb_num-1:0]     match;
	logic                   hit;
	logic [idx_w-1:0]       hit_idx;

	// vpn2 always compared, asid skipped for global entries
	always_comb begin
		for (int i = 0; i < tlb_num; i++) begin
			match[i] = entry_vld[i]
				&& entries[i][entry_vpn2_lsb +: vpn2_w] == tlb.probe_entryhi[31:13]
				&& (entries[i][entry_g_pos]
				|| entries[i][entry_asid_lsb +: asid_w] == tlb.probe_entryhi[asid_w-1:0]);
		end
	end

	// lowest matching index wins
	always_comb begin
		hit     = 1'b0;
		hit_idx = '0;
		for (int i = tlb_num - 1; i >= 0; i--) begin
			if (match[i]) begin
				hit     = 1'b1;
				hit_idx = idx_w'(i);
			end
		end
	end

	assign tlb.lookup_result = hit ? {{(32 - idx_w){1'b0}}, hit_idx} : 32'h8000_0000;
	assign tlb.lookup_entry  = entries[tlb.index];

	// entries never written take no part in a probe
	always_ff @(posedge clk) begin
		if (rst)
			entry_vld <= '0;
		else if (tlb.write_en)
			entry_vld[tlb.index] <= 1'b1;
	end

	always_ff @(posedge clk) begin
		if (tlb.write_en)
			entries[tlb.index] <= tlb.write_entry;
	end

endmodule

// File: rtl/tlb_if.sv
`timescale 1ns/1ps

interface tlb_if #(
	parameter int tlb_num = 16
);
	import cp0_pkg::*;

	localparam int idx_w = $clog2(tlb_num);

	logic [31:0]            probe_entryhi;
	logic [31:0]            probe_result;
	logic                   probe_wen;
	logic [idx_w-1:0]       index;
	logic [tlb_entry_w-1:0] read_entry;
	logic                   read_wen;
	logic [tlb_entry_w-1:0] write_entry;
	logic                   write_en;
	// raw array outputs, registered by the sequencer
	logic [31:0]            lookup_result;
	logic [tlb_entry_w-1:0] lookup_entry;

	modport regs_mp (
		output probe_entryhi, index, write_entry,
		input  probe_result, probe_wen, read_entry, read_wen
	);

	modport seq_mp (
		input  lookup_result, lookup_entry,
		output probe_result, probe_wen, read_entry, read_wen, write_en
	);

	modport array_mp (
		input  probe_entryhi, index, write_entry, write_en,
		output lookup_result, lookup_entry
	);

endinterface

// File: rtl/tlb_seq.sv
`timescale 1ns/1ps

module tlb_seq #(
	parameter int tlb_num = 16
) (
	input  logic             clk,
	input  logic             rst,
	input  logic             tlb_valid,
	input  cp0_pkg::tlb_op_t tlb_op,
	output logic             tlb_ready,
	tlb_if.seq_mp            tlb
);
	import cp0_pkg::*;

	localparam int idx_w = $clog2(tlb_num);

	typedef enum logic [1:0] {
		st_idle,
		st_lookup,
		st_commit
	} state_t;

	state_t                 state;
	tlb_op_t                op_q;
	logic                   accept;
	logic                   miss_q;
	logic [idx_w-1:0]       hit_idx_q;
	logic [tlb_entry_w-1:0] entry_q;

	assign tlb_ready = state == st_idle;
	assign accept    = tlb_valid && tlb_ready;

	always_ff @(posedge clk) begin
		if (rst) begin
			state         <= st_idle;
			tlb.probe_wen <= 1'b0;
			tlb.read_wen  <= 1'b0;
			tlb.write_en  <= 1'b0;
		end else begin
			case (state)
				st_idle: begin
					// tlbwi goes straight to the array write
					if (accept && tlb_op == tlb_op_tlbwi) begin
						state        <= st_commit;
						tlb.write_en <= 1'b1;
					end else if (accept) begin
						state <= st_lookup;
					end
				end
				st_lookup: begin
					state         <= st_commit;
					tlb.probe_wen <= op_q == tlb_op_tlbp;
					tlb.read_wen  <= op_q == tlb_op_tlbr;
				end
				default: begin
					state         <= st_idle;
					tlb.probe_wen <= 1'b0;
					tlb.read_wen  <= 1'b0;
					tlb.write_en  <= 1'b0;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (accept)
			op_q <= tlb_op;
	end

	// array result held for the commit cycle
	always_ff @(posedge clk) begin
		if (state == st_lookup) begin
			miss_q    <= tlb.lookup_result[31];
			hit_idx_q <= tlb.lookup_result[idx_w-1:0];
			entry_q   <= tlb.lookup_entry;
		end
	end

	assign tlb.probe_result = {miss_q, {(31 - idx_w){1'b0}}, hit_idx_q};
	assign tlb.read_entry   = entry_q;

endmodule

// File: run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module tb_cp0 -f all.f -o tb_cp0

./obj_dir/tb_cp0

// File: test/cp0_testdata.txt
// kind addr ctl data aux expect, all hex
// kinds 1 write, 2 read, 3 exc, 4 eret, 5 tlb, 6 int_num, 7 int_happen, 8 epc, 9 idle
02 60 0000 00000000 00000000 00400000
01 60 0000 ffffffff 00000000 00000000
02 60 0000 00000000 00000000 0040ff03
02 61 0000 00000000 00000000 00000000
01 68 0000 ffffffff 00000000 00000000
02 68 0000 00000000 00000000 00000300
07 00 0000 00000000 00000000 00000000
01 60 0000 0000ff01 00000000 00000000
07 00 0000 00000000 00000000 00000001
01 68 0000 00000000 00000000 00000000
06 00 0000 00000004 00000000 00000000
07 00 0000 00000000 00000000 00000001
02 68 0000 00000000 00000000 00001000
01 60 0000 0000ef01 00000000 00000000
07 00 0000 00000000 00000000 00000000
06 00 0000 00000000 00000000 00000000
01 60 0000 00000000 00000000 00000000
01 70 0000 12345678 00000000 00000000
02 70 0000 00000000 00000000 12345678
01 50 0000 ffffffff 00000000 00000000
02 50 0000 00000000 00000000 ffffe0ff
01 10 0000 ffffffff 00000000 00000000
02 10 0000 00000000 00000000 03ffffff
// syscall, then ri with ov in a delay slot, then ades with EXL set
03 00 0400 bfc00100 00000000 00000000
02 60 0000 00000000 00000000 00400002
02 68 0000 00000000 00000000 00000020
08 00 0000 00000000 00000000 bfc00100
04 00 0000 00000000 00000000 00000000
02 60 0000 00000000 00000000 00400000
03 00 8180 80001004 00000000 00000000
03 00 0800 80002000 00400003 00000000
02 68 0000 00000000 00000000 80000014
08 00 0000 00000000 00000000 80001000
02 40 0000 00000000 00000000 00400003
04 00 0000 00000000 00000000 00000000
03 00 6000 80003000 bad00001 00000000
02 68 0000 00000000 00000000 00000000
08 00 0000 00000000 00000000 80003000
// timer
01 48 0000 00000000 00000000 00000000
01 58 0000 00000003 00000000 00000000
09 00 000a 00000000 00000000 00000000
02 68 0000 00000000 00000000 40008000
01 58 0000 00000100 00000000 00000000
02 68 0000 00000000 00000000 00000000
// tlb entries 3 and 9, entry 9 global
01 50 0000 00800012 00000000 00000000
01 10 0000 00001016 00000000 00000000
01 18 0000 00001057 00000000 00000000
01 00 0000 00000003 00000000 00000000
05 00 0002 00000000 00000000 00000000
01 50 0000 7fff2005 00000000 00000000
01 10 0000 00a00003 00000000 00000000
01 18 0000 00b00005 00000000 00000000
01 00 0000 00000009 00000000 00000000
05 00 0002 00000000 00000000 00000000
01 50 0000 7fff20ab 00000000 00000000
05 00 0100 00000000 00000000 00000000
05 00 0001 00000000 00000000 00000001
02 00 0000 00000000 00000000 00000009
02 50 0000 00000000 00000000 7fff2005
02 10 0000 00000000 00000000 00a00003
01 50 0000 00800012 00000000 00000000
05 00 0000 00000000 00000000 00000000
02 00 0000 00000000 00000000 00000003
01 50 0000 00800013 00000000 00000000
05 00 0000 00000000 00000000 00000000
02 00 0000 00000000 00000000 80000000
01 00 0000 00000003 00000000 00000000
05 00 0001 00000000 00000000 00000000
02 50 0000 00000000 00000000 00800012
02 10 0000 00000000 00000000 00001016
02 18 0000 00000000 00000000 00001056
00 00 0000 00000000 00000000 00000000

// File: test/tb_cp0.sv
`timescale 1ns/1ps

module tb_cp0;
	import cp0_pkg::*;

	localparam int max_steps = 128;
	localparam int step_w    = 6;

	// step kinds in the data file
	localparam int k_write = 1;
	localparam int k_read  = 2;
	localparam int k_exc   = 3;
	localparam int k_eret  = 4;
	localparam int k_tlb   = 5;
	localparam int k_irq   = 6;
	localparam int k_int   = 7;
	localparam int k_epc   = 8;
	localparam int k_idle  = 9;

	logic        clk;
	logic        rst;
	logic        cp0_wen;
	logic [7:0]  cp0_addr;
	logic [31:0] cp0_wdata;
	logic [31:0] cp0_rdata;
	logic [14:0] exc_type;
	logic [31:0] pc;
	logic        is_slot;
	logic [5:0]  int_num;
	logic [31:0] bad_vaddr;
	logic        eret;
	logic [31:0] epc;
	logic        int_happen;
	logic        tlb_valid;
	logic [1:0]  tlb_op;
	logic        tlb_ready;

	logic [31:0] steps [max_steps * step_w];
	logic [31:0] lcg_state;
	int          n_steps;
	int          cycles = 0;
	int          cycle_limit;

	cp0_top #(
		.tlb_num(16)
	) u_dut (
		.clk        (clk),
		.rst        (rst),
		.cp0_wen    (cp0_wen),
		.cp0_addr   (cp0_addr),
		.cp0_wdata  (cp0_wdata),
		.cp0_rdata  (cp0_rdata),
		.exc_type   (exc_type),
		.pc         (pc),
		.is_slot    (is_slot),
		.int_num    (int_num),
		.bad_vaddr  (bad_vaddr),
		.eret       (eret),
		.epc        (epc),
		.int_happen (int_happen),
		.tlb_valid  (tlb_valid),
		.tlb_op     (tlb_op),
		.tlb_ready  (tlb_ready)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles > cycle_limit) begin
			$display("timeout: test steps still running after %0d cycles", cycles);
			$display("Verification failed");
			$fatal(1);
		end
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("mismatch at %0t ns: %s is %h, expected %h", $time, name, got, exp);
			$display("Verification failed");
			$fatal(1);
		end
	endtask

	// quiet cycle, pc and bad_vaddr carry noise
	task automatic drive_idle();
		cp0_wen   <= 1'b0;
		exc_type  <= '0;
		is_slot   <= 1'b0;
		eret      <= 1'b0;
		lcg_state = lcg_next(lcg_state);
		pc        <= lcg_state;
		lcg_state = lcg_next(lcg_state);
		bad_vaddr <= lcg_state;
	endtask

	task automatic run_step(input int i);
		logic [31:0] kind;
		logic [7:0]  addr;
		logic [15:0] ctl;
		logic [31:0] data;
		logic [31:0] aux;
		logic [31:0] exp_val;
		reg_num_t    reg_sel;
		int          waits;
		kind    = steps[i * step_w];
		addr    = steps[i * step_w + 1][7:0];
		ctl     = steps[i * step_w + 2][15:0];
		data    = steps[i * step_w + 3];
		aux     = steps[i * step_w + 4];
		exp_val = steps[i * step_w + 5];
		reg_sel = reg_num_t'(addr[7:3]);
		@(posedge clk);
		drive_idle();
		case (kind)
			k_write: begin
				cp0_wen   <= 1'b1;
				cp0_addr  <= addr;
				cp0_wdata <= data;
			end
			k_read: begin
				cp0_addr <= addr;
				@(negedge clk);
				check_eq($sformatf("cp0_rdata %s", reg_sel.name()), cp0_rdata, exp_val);
			end
			k_exc: begin
				exc_type  <= ctl[14:0];
				is_slot   <= ctl[15];
				pc        <= data;
				bad_vaddr <= aux;
			end
			k_eret: eret <= 1'b1;
			k_irq: int_num <= data[5:0];
			k_int: begin
				@(negedge clk);
				check_eq("int_happen", {31'b0, int_happen}, exp_val);
			end
			k_epc: begin
				@(negedge clk);
				check_eq("epc", epc, exp_val);
			end
			k_idle: begin
				repeat (ctl) begin
					@(posedge clk);
					drive_idle();
				end
			end
			k_tlb: begin
				// valid and op held until the handshake
				tlb_valid <= 1'b1;
				tlb_op    <= ctl[1:0];
				waits = 0;
				@(negedge clk);
				while (!tlb_ready) begin
					@(negedge clk);
					waits++;
				end
				@(posedge clk);
				drive_idle();
				tlb_valid <= 1'b0;
				// bit 8 leaves the command running for the next step
				if (!ctl[8]) begin
					@(negedge clk);
					while (!tlb_ready)
						@(negedge clk);
				end
				check_eq("tlb_valid wait cycles", 32'(waits), exp_val);
			end
			default: begin
				$display("unknown step kind %0d at step %0d", kind, i);
				$display("Verification failed");
				$fatal(1);
			end
		endcase
	endtask

	initial begin
		rst       = 1'b1;
		cp0_wen   = 1'b0;
		cp0_addr  = 8'h0;
		cp0_wdata = 32'h0;
		exc_type  = 15'h0;
		pc        = 32'h0;
		is_slot   = 1'b0;
		int_num   = 6'h0;
		bad_vaddr = 32'h0;
		eret      = 1'b0;
		tlb_valid = 1'b0;
		tlb_op    = 2'd0;
		lcg_state = 32'hcba99345;
		for (int i = 0; i < max_steps * step_w; i++)
			steps[i] = 32'h0;
		$readmemh("test/cp0_testdata.txt", steps);
		n_steps = 0;
		while (n_steps < max_steps && steps[n_steps * step_w] != 32'h0)
			n_steps++;
		cycle_limit = 20 * n_steps;
		if (n_steps == 0) begin
			$display("no test steps found in test/cp0_testdata.txt");
			$display("Verification failed");
			$fatal(1);
		end
		repeat (8) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		check_eq("tlb_ready", {31'b0, tlb_ready}, 32'd1);
		for (int i = 0; i < n_steps; i++)
			run_step(i);
		$display("Verification passed");
		$finish;
	end

endmodule
